// ==== sim.f ====
+incdir+source
source/tageTypesPkg.sv
source/tageHashPkg.sv
source/requestStage.sv
source/baseTable.sv
source/taggedTable.sv
source/providerSelect.sv
source/tageTop.sv
tests/tageTb.sv

// ==== Bender.yml ====
package:
  name: tage_predictor

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/tageTypesPkg.sv
      - source/tageHashPkg.sv
      - source/requestStage.sv
      - source/baseTable.sv
      - source/taggedTable.sv
      - source/providerSelect.sv
      - source/tageTop.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - tests/tageTb.sv

// ==== tests/tageTb.sv ====
`default_nettype none

`include "tage_settings.svh"

module tageTb;

    import tageTypesPkg::*;
    import tageHashPkg::*;

    localparam int clkPeriod     = 10;
    localparam int numTests      = 6;
    localparam int cyclesPerTest = 200;
    localparam int maxEntries    = 256;

    logic                      Clk;
    logic                      reset;
    logic                      reqValid;
    logic [`TAGE_PC_BITS-1:0]  reqPc;
    logic                      reqReady;
    logic                      respValid;
    logic                      respTaken;
    ctrT                       respCounter;
    tableIdT                   respProvider;
    usefulT                    respUseful;
    logic                      respReady;
    logic                      updValid;
    logic [`TAGE_PC_BITS-1:0]  updPc;
    logic [`TAGE_GHR_BITS-1:0] updHist;
    tableIdT                   updTable;
    ctrT                       updCounter;
    usefulT                    updUseful;
    logic                      updTaken;

    // reference model state
    logic [`TAGE_GHR_BITS-1:0] mHist;
    ctrT                       mBase [1 << `TAGE_BASE_IDX_BITS];
    logic                      mValid [1:4][maxEntries];
    logic [15:0]               mTag [1:4][maxEntries];
    ctrT                       mCtr [1:4][maxEntries];
    usefulT                    mUseful [1:4][maxEntries];

    // expected responses in request order
    tableIdT expProv [$];
    ctrT     expCtr [$];
    usefulT  expUseful [$];

    integer  seed = 32'hee9400a0;
    string   testName = "reset";
    int      acceptCount = 0;
    logic    sawStall = 1'b0;
    logic    heldValid = 1'b0;
    logic    heldTaken;
    ctrT     heldCtr;
    tableIdT heldProv;
    usefulT  heldUseful;

    tageTop dut0 (
        .Clk(Clk), .reset(reset), .reqValid(reqValid), .reqPc(reqPc), .reqReady(reqReady),
        .respValid(respValid), .respTaken(respTaken), .respCounter(respCounter),
        .respProvider(respProvider), .respUseful(respUseful), .respReady(respReady),
        .updValid(updValid), .updPc(updPc), .updHist(updHist), .updTable(updTable),
        .updCounter(updCounter), .updUseful(updUseful), .updTaken(updTaken)
    );

    initial begin
        Clk = 1'b0;
        forever #(clkPeriod / 2) Clk = ~Clk;
    end

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(input string field, input int expVal, input int actVal);
        assert (expVal == actVal) else
            stopWithError($sformatf("Fail %s %s expected %0d actual %0d",
                testName, field, expVal, actVal));
    endtask

    function automatic int geoIdx(input int t);
        case (t)
            1: return `TAGE_T1_IDX_BITS;
            2: return `TAGE_T2_IDX_BITS;
            3: return `TAGE_T3_IDX_BITS;
            default: return `TAGE_T4_IDX_BITS;
        endcase
    endfunction

    function automatic int geoTag(input int t);
        case (t)
            1: return `TAGE_T1_TAG_BITS;
            2: return `TAGE_T2_TAG_BITS;
            3: return `TAGE_T3_TAG_BITS;
            default: return `TAGE_T4_TAG_BITS;
        endcase
    endfunction

    function automatic int geoHist(input int t);
        case (t)
            1: return `TAGE_T1_HIST_LEN;
            2: return `TAGE_T2_HIST_LEN;
            3: return `TAGE_T3_HIST_LEN;
            default: return `TAGE_T4_HIST_LEN;
        endcase
    endfunction

    function automatic int modelIndex(input int t, input logic [`TAGE_PC_BITS-1:0] pc,
                                      input logic [`TAGE_GHR_BITS-1:0] hist);
        return int'(tableIndex(pc, hist, geoIdx(t), geoHist(t))) & ((1 << geoIdx(t)) - 1);
    endfunction

    function automatic logic [15:0] modelTag(input int t, input logic [`TAGE_PC_BITS-1:0] pc,
                                             input logic [`TAGE_GHR_BITS-1:0] hist);
        return tableTag(pc, hist, geoTag(t), geoHist(t)) & ((16'd1 << geoTag(t)) - 16'd1);
    endfunction

    // longest matching table wins, base table otherwise
    task automatic predict(input logic [`TAGE_PC_BITS-1:0] pc, output tableIdT prov,
                           output ctrT ctr, output usefulT useful);
        int idx;
        prov   = tableBase;
        ctr    = mBase[pc[`TAGE_OFFSET_BITS +: `TAGE_BASE_IDX_BITS]];
        useful = '0;
        for (int t = 4; t >= 1; t--) begin
            idx = modelIndex(t, pc, mHist);
            if (prov == tableBase && mValid[t][idx] && mTag[t][idx] == modelTag(t, pc, mHist)) begin
                prov   = tableIdT'(t);
                ctr    = mCtr[t][idx];
                useful = mUseful[t][idx];
            end
        end
    endtask

    // sampled mid-cycle on the values that decide the next rising edge
    always @(negedge Clk) begin : monitor
        tableIdT pProv;
        ctrT     pCtr;
        usefulT  pUseful;
        int      t;
        int      idx;
        if (!reset) begin
            if (reqValid && reqReady) begin
                predict(reqPc, pProv, pCtr, pUseful);
                expProv.push_back(pProv);
                expCtr.push_back(pCtr);
                expUseful.push_back(pUseful);
                acceptCount++;
            end
            if (updValid) begin
                if (updTable == tableBase) begin
                    mBase[updPc[`TAGE_OFFSET_BITS +: `TAGE_BASE_IDX_BITS]] = updCounter;
                end else begin
                    t   = int'(updTable);
                    idx = modelIndex(t, updPc, updHist);
                    mValid[t][idx]  = 1'b1;
                    mTag[t][idx]    = modelTag(t, updPc, updHist);
                    mCtr[t][idx]    = updCounter;
                    mUseful[t][idx] = updUseful;
                end
                mHist = {mHist[`TAGE_GHR_BITS-2:0], updTaken};
            end
            if (heldValid) begin
                assert (respValid) else stopWithError("respValid dropped while stalled");
                checkValue("heldTaken", heldTaken, respTaken);
                checkValue("heldCounter", heldCtr, respCounter);
                checkValue("heldProvider", heldProv, respProvider);
                checkValue("heldUseful", heldUseful, respUseful);
            end
            if (respValid && !respReady) begin
                sawStall = 1'b1;
                assert (!reqReady) else stopWithError("reqReady stayed high during a stall");
            end
            if (respValid && respReady) begin
                assert (expProv.size() > 0) else
                    stopWithError("a response arrived without an accepted request");
                checkValue("provider", expProv[0], respProvider);
                checkValue("counter", expCtr[0], respCounter);
                checkValue("taken", expCtr[0] >= 4, respTaken);
                checkValue("useful", expUseful[0], respUseful);
                void'(expProv.pop_front());
                void'(expCtr.pop_front());
                void'(expUseful.pop_front());
            end
            heldValid  = respValid && !respReady;
            heldTaken  = respTaken;
            heldCtr    = respCounter;
            heldProv   = respProvider;
            heldUseful = respUseful;
        end
    end

    // all drive tasks start and end 1 unit after a rising edge
    task automatic lookup(input logic [`TAGE_PC_BITS-1:0] pc);
        reqPc    = pc;
        reqValid = 1'b1;
        while (!reqReady) begin
            @(posedge Clk);
            #1;
        end
        @(posedge Clk);
        #1;
        reqValid = 1'b0;
        while (expProv.size() != 0) begin
            @(posedge Clk);
            #1;
        end
        @(posedge Clk);
        #1;
    endtask

    task automatic update(input logic [`TAGE_PC_BITS-1:0] pc,
                          input logic [`TAGE_GHR_BITS-1:0] hist, input tableIdT tbl,
                          input ctrT ctr, input usefulT useful, input logic taken);
        updPc      = pc;
        updHist    = hist;
        updTable   = tbl;
        updCounter = ctr;
        updUseful  = useful;
        updTaken   = taken;
        updValid   = 1'b1;
        @(posedge Clk);
        #1;
        updValid = 1'b0;
        @(posedge Clk);
        #1;
    endtask

    task automatic stallBurst(input int count);
        int base;
        int last;
        int cycle;
        base      = acceptCount;
        last      = acceptCount;
        cycle     = 0;
        respReady = 1'b0;
        reqValid  = 1'b1;
        reqPc     = $random(seed);
        while (acceptCount - base < count) begin
            @(posedge Clk);
            #1;
            cycle++;
            // hold the response for a while and then release it at random
            respReady = (cycle < 8) ? 1'b0 : 1'($random(seed));
            if (acceptCount != last) begin
                last  = acceptCount;
                reqPc = $random(seed);
            end
        end
        reqValid  = 1'b0;
        respReady = 1'b1;
        while (expProv.size() != 0) begin
            @(posedge Clk);
            #1;
        end
    endtask

    initial begin : watchdog
        #(numTests * cyclesPerTest * clkPeriod);
        stopWithError("Timeout: the tests did not finish within the allowed time");
    end

    initial begin : stimulus
        logic [`TAGE_PC_BITS-1:0]  pc;
        logic [`TAGE_GHR_BITS-1:0] hist;
        logic                      a;
        logic                      b;
        reset = 1'b1;
        reqValid = 1'b0;
        reqPc = '0;
        respReady = 1'b1;
        updValid = 1'b0;
        updPc = '0;
        updHist = '0;
        updTable = tableBase;
        updCounter = '0;
        updUseful = '0;
        updTaken = 1'b0;
        mHist = '0;
        foreach (mBase[i]) mBase[i] = ctrT'(`TAGE_CTR_RESET);
        foreach (mValid[t, i]) mValid[t][i] = 1'b0;
        repeat (2) @(posedge Clk);
        #1;
        reset = 1'b0;

        testName = "resetDefault";
        repeat (8) lookup($random(seed));

        testName = "baseWrite";
        pc = $random(seed);
        update(pc, {mHist[`TAGE_GHR_BITS-2:0], 1'b1}, tableBase, 3'd6, 2'd0, 1'b1);
        lookup(pc);

        // updHist is the history after this update's own shift
        testName = "taggedT2";
        pc   = $random(seed);
        a    = $random(seed);
        hist = {mHist[`TAGE_GHR_BITS-2:0], a};
        update(pc, hist, tableT2, 3'd5, 2'd2, a);
        lookup(pc);

        testName = "longestMatch";
        pc   = $random(seed);
        a    = $random(seed);
        b    = $random(seed);
        hist = {mHist[`TAGE_GHR_BITS-3:0], a, b};
        update(pc, hist, tableT1, 3'd2, 2'd1, a);
        update(pc, hist, tableT4, 3'd7, 2'd3, b);
        lookup(pc);

        testName = "historyChange";
        update(pc, {mHist[`TAGE_GHR_BITS-2:0], !b}, tableBase,
               mBase[pc[`TAGE_OFFSET_BITS +: `TAGE_BASE_IDX_BITS]], 2'd0, !b);
        lookup(pc);

        testName = "backPressure";
        stallBurst(16);
        assert (sawStall) else stopWithError("the response channel never stalled");
        // a stray extra response would find the expected queue empty
        repeat (4) @(posedge Clk);
        #1;

        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/tageTop.sv ====
`default_nettype none

`include "tage_settings.svh"

module tageTop (
    input  logic                      Clk,
    input  logic                      reset,
    input  logic                      reqValid,
    input  logic [`TAGE_PC_BITS-1:0]  reqPc,
    output logic                      reqReady,
    output logic                      respValid,
    output logic                      respTaken,
    output tageTypesPkg::ctrT         respCounter,
    output tageTypesPkg::tableIdT     respProvider,
    output tageTypesPkg::usefulT      respUseful,
    input  logic                      respReady,
    input  logic                      updValid,
    input  logic [`TAGE_PC_BITS-1:0]  updPc,
    input  logic [`TAGE_GHR_BITS-1:0] updHist,
    input  tageTypesPkg::tableIdT     updTable,
    input  tageTypesPkg::ctrT         updCounter,
    input  tageTypesPkg::usefulT      updUseful,
    input  logic                      updTaken
);

    import tageTypesPkg::*;

    logic                      stall;
    logic                      lookupEn;
    logic [`TAGE_GHR_BITS-1:0] lookupHist;
    logic                      s1Valid;
    ctrT                       baseCounter;
    logic                      hit [1:4];
    ctrT                       counter [1:4];
    usefulT                    useful [1:4];

    requestStage request0 (
        .Clk        (Clk),
        .reset      (reset),
        .reqValid   (reqValid),
        .reqReady   (reqReady),
        .updValid   (updValid),
        .updTaken   (updTaken),
        .stall      (stall),
        .lookupEn   (lookupEn),
        .lookupHist (lookupHist),
        .s1Valid    (s1Valid)
    );

    baseTable base0 (
        .Clk         (Clk),
        .reset       (reset),
        .lookupEn    (lookupEn),
        .stall       (stall),
        .reqPc       (reqPc),
        .updValid    (updValid),
        .updTable    (updTable),
        .updPc       (updPc),
        .updCounter  (updCounter),
        .baseCounter (baseCounter)
    );

    // T1 shortest history through T4 longest
    taggedTable #(.tableNum(tableT1), .idxBits(`TAGE_T1_IDX_BITS),
        .tagBits(`TAGE_T1_TAG_BITS), .histLen(`TAGE_T1_HIST_LEN)) t1 (
        .Clk(Clk), .reset(reset), .lookupEn(lookupEn), .stall(stall),
        .reqPc(reqPc), .lookupHist(lookupHist), .updValid(updValid),
        .updTable(updTable), .updPc(updPc), .updHist(updHist),
        .updCounter(updCounter), .updUseful(updUseful),
        .hit(hit[1]), .counter(counter[1]), .useful(useful[1])
    );

    taggedTable #(.tableNum(tableT2), .idxBits(`TAGE_T2_IDX_BITS),
        .tagBits(`TAGE_T2_TAG_BITS), .histLen(`TAGE_T2_HIST_LEN)) t2 (
        .Clk(Clk), .reset(reset), .lookupEn(lookupEn), .stall(stall),
        .reqPc(reqPc), .lookupHist(lookupHist), .updValid(updValid),
        .updTable(updTable), .updPc(updPc), .updHist(updHist),
        .updCounter(updCounter), .updUseful(updUseful),
        .hit(hit[2]), .counter(counter[2]), .useful(useful[2])
    );

    taggedTable #(.tableNum(tableT3), .idxBits(`TAGE_T3_IDX_BITS),
        .tagBits(`TAGE_T3_TAG_BITS), .histLen(`TAGE_T3_HIST_LEN)) t3 (
        .Clk(Clk), .reset(reset), .lookupEn(lookupEn), .stall(stall),
        .reqPc(reqPc), .lookupHist(lookupHist), .updValid(updValid),
        .updTable(updTable), .updPc(updPc), .updHist(updHist),
        .updCounter(updCounter), .updUseful(updUseful),
        .hit(hit[3]), .counter(counter[3]), .useful(useful[3])
    );

    taggedTable #(.tableNum(tableT4), .idxBits(`TAGE_T4_IDX_BITS),
        .tagBits(`TAGE_T4_TAG_BITS), .histLen(`TAGE_T4_HIST_LEN)) t4 (
        .Clk(Clk), .reset(reset), .lookupEn(lookupEn), .stall(stall),
        .reqPc(reqPc), .lookupHist(lookupHist), .updValid(updValid),
        .updTable(updTable), .updPc(updPc), .updHist(updHist),
        .updCounter(updCounter), .updUseful(updUseful),
        .hit(hit[4]), .counter(counter[4]), .useful(useful[4])
    );

    providerSelect select0 (
        .Clk          (Clk),
        .reset        (reset),
        .s1Valid      (s1Valid),
        .respReady    (respReady),
        .baseCounter  (baseCounter),
        .hit1         (hit[1]),
        .hit2         (hit[2]),
        .hit3         (hit[3]),
        .hit4         (hit[4]),
        .counter1     (counter[1]),
        .counter2     (counter[2]),
        .counter3     (counter[3]),
        .counter4     (counter[4]),
        .useful1      (useful[1]),
        .useful2      (useful[2]),
        .useful3      (useful[3]),
        .useful4      (useful[4]),
        .stall        (stall),
        .respValid    (respValid),
        .respTaken    (respTaken),
        .respCounter  (respCounter),
        .respProvider (respProvider),
        .respUseful   (respUseful)
    );

endmodule

`default_nettype wire

// ==== source/providerSelect.sv ====
`default_nettype none

module providerSelect (
    input  logic                  Clk,
    input  logic                  reset,
    input  logic                  s1Valid,
    input  logic                  respReady,
    input  tageTypesPkg::ctrT     baseCounter,
    input  logic                  hit1,
    input  logic                  hit2,
    input  logic                  hit3,
    input  logic                  hit4,
    input  tageTypesPkg::ctrT     counter1,
    input  tageTypesPkg::ctrT     counter2,
    input  tageTypesPkg::ctrT     counter3,
    input  tageTypesPkg::ctrT     counter4,
    input  tageTypesPkg::usefulT  useful1,
    input  tageTypesPkg::usefulT  useful2,
    input  tageTypesPkg::usefulT  useful3,
    input  tageTypesPkg::usefulT  useful4,
    output logic                  stall,
    output logic                  respValid,
    output logic                  respTaken,
    output tageTypesPkg::ctrT     respCounter,
    output tageTypesPkg::tableIdT respProvider,
    output tageTypesPkg::usefulT  respUseful
);

    import tageTypesPkg::*;

    ctrT     selCounter;
    tableIdT selProvider;
    usefulT  selUseful;

    // held response that nobody takes freezes the whole pipe
    assign stall = respValid && !respReady;

    // longest history wins
    always_comb begin
        if (hit4) begin
            selCounter  = counter4;
            selProvider = tableT4;
            selUseful   = useful4;
        end else if (hit3) begin
            selCounter  = counter3;
            selProvider = tableT3;
            selUseful   = useful3;
        end else if (hit2) begin
            selCounter  = counter2;
            selProvider = tableT2;
            selUseful   = useful2;
        end else if (hit1) begin
            selCounter  = counter1;
            selProvider = tableT1;
            selUseful   = useful1;
        end else begin
            selCounter  = baseCounter;
            selProvider = tableBase;
            selUseful   = '0;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            respValid <= 1'b0;
        end else if (!stall) begin
            respValid <= s1Valid;
        end
    end

    always_ff @(posedge Clk) begin
        if (!stall && s1Valid) begin
            respCounter  <= selCounter;
            respTaken    <= ctrTaken(selCounter);
            respProvider <= selProvider;
            respUseful   <= selUseful;
        end
    end

endmodule

`default_nettype wire

// ==== source/taggedTable.sv ====
`default_nettype none

`include "tage_settings.svh"

module taggedTable #(
    parameter tageTypesPkg::tableIdT tableNum = tageTypesPkg::tableT1,
    parameter int                    idxBits  = 7,
    parameter int                    tagBits  = 7,
    parameter int                    histLen  = 4
) (
    input  logic                      Clk,
    input  logic                      reset,
    input  logic                      lookupEn,
    input  logic                      stall,
    input  logic [`TAGE_PC_BITS-1:0]  reqPc,
    input  logic [`TAGE_GHR_BITS-1:0] lookupHist,
    input  logic                      updValid,
    input  tageTypesPkg::tableIdT     updTable,
    input  logic [`TAGE_PC_BITS-1:0]  updPc,
    input  logic [`TAGE_GHR_BITS-1:0] updHist,
    input  tageTypesPkg::ctrT         updCounter,
    input  tageTypesPkg::usefulT      updUseful,
    output logic                      hit,
    output tageTypesPkg::ctrT         counter,
    output tageTypesPkg::usefulT      useful
);

    import tageTypesPkg::*;
    import tageHashPkg::*;

    localparam int entries = 1 << idxBits;

    logic               entryValid  [entries];
    logic [tagBits-1:0] entryTag    [entries];
    ctrT                entryCtr    [entries];
    usefulT             entryUseful [entries];

    logic [`TAGE_HASH_BITS-1:0] readIdxHash;
    logic [`TAGE_HASH_BITS-1:0] readTagHash;
    logic [`TAGE_HASH_BITS-1:0] writeIdxHash;
    logic [`TAGE_HASH_BITS-1:0] writeTagHash;
    logic [idxBits-1:0]         readIdx;
    logic [tagBits-1:0]         readTag;
    logic [idxBits-1:0]         writeIdx;
    logic [tagBits-1:0]         writeTag;
    logic                       writeEn;
    logic                       capture;

    // lookup side hashes the live history, update side the one it carries
    assign readIdxHash  = tableIndex(reqPc, lookupHist, idxBits, histLen);
    assign readTagHash  = tableTag(reqPc, lookupHist, tagBits, histLen);
    assign writeIdxHash = tableIndex(updPc, updHist, idxBits, histLen);
    assign writeTagHash = tableTag(updPc, updHist, tagBits, histLen);

    assign readIdx  = readIdxHash[idxBits-1:0];
    assign readTag  = readTagHash[tagBits-1:0];
    assign writeIdx = writeIdxHash[idxBits-1:0];
    assign writeTag = writeTagHash[tagBits-1:0];

    assign writeEn = updValid && (updTable == tableNum);
    assign capture = lookupEn && !stall;

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                entryValid[i] <= 1'b0;
            end
        end else if (writeEn) begin
            entryValid[writeIdx] <= 1'b1;
        end
    end

    always_ff @(posedge Clk) begin
        if (writeEn) begin
            entryTag[writeIdx]    <= writeTag;
            entryCtr[writeIdx]    <= updCounter;
            entryUseful[writeIdx] <= updUseful;
        end
    end

    // stage 1 result
    always_ff @(posedge Clk) begin
        if (reset) begin
            hit <= 1'b0;
        end else if (capture) begin
            hit <= entryValid[readIdx] && (entryTag[readIdx] == readTag);
        end
    end

    always_ff @(posedge Clk) begin
        if (capture) begin
            counter <= entryCtr[readIdx];
            useful  <= entryUseful[readIdx];
        end
    end

endmodule

`default_nettype wire

// ==== source/baseTable.sv ====
`default_nettype none

`include "tage_settings.svh"

module baseTable (
    input  logic                     Clk,
    input  logic                     reset,
    input  logic                     lookupEn,
    input  logic                     stall,
    input  logic [`TAGE_PC_BITS-1:0] reqPc,
    input  logic                     updValid,
    input  tageTypesPkg::tableIdT    updTable,
    input  logic [`TAGE_PC_BITS-1:0] updPc,
    input  tageTypesPkg::ctrT        updCounter,
    output tageTypesPkg::ctrT        baseCounter
);

    import tageTypesPkg::*;

    localparam int entries = 1 << `TAGE_BASE_IDX_BITS;

    ctrT                           counters [entries];
    logic [`TAGE_BASE_IDX_BITS-1:0] readIdx;
    logic [`TAGE_BASE_IDX_BITS-1:0] writeIdx;
    logic                          writeEn;
    logic                          capture;

    // pc only, no history for the base table
    assign readIdx  = reqPc[`TAGE_OFFSET_BITS +: `TAGE_BASE_IDX_BITS];
    assign writeIdx = updPc[`TAGE_OFFSET_BITS +: `TAGE_BASE_IDX_BITS];
    assign writeEn  = updValid && (updTable == tableBase);
    assign capture  = lookupEn && !stall;

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < entries; i++) begin
                counters[i] <= ctrT'(`TAGE_CTR_RESET);
            end
        end else if (writeEn) begin
            counters[writeIdx] <= updCounter;
        end
    end

    // read happens before the write on the same edge
    always_ff @(posedge Clk) begin
        if (capture) begin
            baseCounter <= counters[readIdx];
        end
    end

endmodule

`default_nettype wire

// ==== source/requestStage.sv ====
`default_nettype none

`include "tage_settings.svh"

module requestStage (
    input  logic                      Clk,
    input  logic                      reset,
    input  logic                      reqValid,
    output logic                      reqReady,
    input  logic                      updValid,
    input  logic                      updTaken,
    input  logic                      stall,
    output logic                      lookupEn,
    output logic [`TAGE_GHR_BITS-1:0] lookupHist,
    output logic                      s1Valid
);

    // bit 0 holds the newest resolved outcome
    logic [`TAGE_GHR_BITS-1:0] ghr;

    assign reqReady   = !stall;
    assign lookupEn   = reqValid && reqReady;
    // lookups see the history before this edge's shift
    assign lookupHist = ghr;

    always_ff @(posedge Clk) begin
        if (reset) begin
            ghr <= '0;
        end else if (updValid) begin
            ghr <= {ghr[`TAGE_GHR_BITS-2:0], updTaken};
        end
    end

    // stage 1 occupancy, frozen while the response is held
    always_ff @(posedge Clk) begin
        if (reset) begin
            s1Valid <= 1'b0;
        end else if (!stall) begin
            s1Valid <= lookupEn;
        end
    end

endmodule

`default_nettype wire

// ==== source/tageHashPkg.sv ====
`default_nettype none

`include "tage_settings.svh"

package tageHashPkg;

    // xor of width-sized chunks from bit 0, last chunk zero padded
    function automatic logic [`TAGE_HASH_BITS-1:0] foldBits(
        input logic [`TAGE_GHR_BITS-1:0] value,
        input int                        valueBits,
        input int                        width
    );
        logic [`TAGE_HASH_BITS-1:0] folded;
        folded = '0;
        for (int i = 0; i < `TAGE_GHR_BITS; i++) begin
            if (i < valueBits) begin
                folded[i % width] = folded[i % width] ^ value[i];
            end
        end
        return folded;
    endfunction

    function automatic logic [`TAGE_HASH_BITS-1:0] tableIndex(
        input logic [`TAGE_PC_BITS-1:0]  pc,
        input logic [`TAGE_GHR_BITS-1:0] hist,
        input int                        idxBits,
        input int                        histLen
    );
        logic [`TAGE_GHR_BITS-1:0] pcBits;
        pcBits = `TAGE_GHR_BITS'(pc >> `TAGE_OFFSET_BITS);
        // a single chunk, so this is just the low idxBits of the pc
        return foldBits(pcBits, idxBits, idxBits) ^ foldBits(hist, histLen, idxBits);
    endfunction

    function automatic logic [`TAGE_HASH_BITS-1:0] tableTag(
        input logic [`TAGE_PC_BITS-1:0]  pc,
        input logic [`TAGE_GHR_BITS-1:0] hist,
        input int                        tagBits,
        input int                        histLen
    );
        logic [`TAGE_GHR_BITS-1:0] pcBits;
        pcBits = `TAGE_GHR_BITS'(pc >> `TAGE_TAG_PC_LSB);
        return foldBits(pcBits, `TAGE_PC_BITS - `TAGE_TAG_PC_LSB, tagBits)
            ^ foldBits(hist, histLen, tagBits);
    endfunction

endpackage

`default_nettype wire

// ==== source/tageTypesPkg.sv ====
`default_nettype none

`include "tage_settings.svh"

package tageTypesPkg;

    // provider id, base first, longest history last
    typedef enum logic [2:0] {
        tableBase,
        tableT1,
        tableT2,
        tableT3,
        tableT4
    } tableIdT;

    // 3-bit saturating direction counter
    typedef logic [`TAGE_CTR_BITS-1:0] ctrT;

    typedef logic [`TAGE_USEFUL_BITS-1:0] usefulT;

    // upper half of the counter range means taken
    function automatic logic ctrTaken(input ctrT ctr);
        return ctr[`TAGE_CTR_BITS-1];
    endfunction

endpackage

`default_nettype wire

// ==== source/tage_settings.svh ====
`ifndef TAGE_SETTINGS_SVH
`define TAGE_SETTINGS_SVH

// address and history widths
`define TAGE_PC_BITS        32
`define TAGE_GHR_BITS       64
`define TAGE_OFFSET_BITS    5
`define TAGE_TAG_PC_LSB     12

// hash results are this wide, callers keep the low bits
`define TAGE_HASH_BITS      16

// base table
`define TAGE_BASE_IDX_BITS  7
`define TAGE_CTR_BITS       3
`define TAGE_USEFUL_BITS    2
`define TAGE_CTR_RESET      3

// tagged table geometry
`define TAGE_T1_IDX_BITS    7
`define TAGE_T1_TAG_BITS    7
`define TAGE_T1_HIST_LEN    4
`define TAGE_T2_IDX_BITS    8
`define TAGE_T2_TAG_BITS    8
`define TAGE_T2_HIST_LEN    8
`define TAGE_T3_IDX_BITS    8
`define TAGE_T3_TAG_BITS    8
`define TAGE_T3_HIST_LEN    16
`define TAGE_T4_IDX_BITS    7
`define TAGE_T4_TAG_BITS    9
`define TAGE_T4_HIST_LEN    64

`endif
